// ==== flist.f ====
+incdir+source
source/ula_pkg.sv
source/raster_timing.sv
source/port_regs.sv
source/pixel_mixer.sv
source/ula_top.sv
sim/tb_ula.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ula
RTL_TOP ?= ula_top
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
RTL ?= source/ula_pkg.sv source/raster_timing.sv source/port_regs.sv \
	source/pixel_mixer.sv source/ula_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+source --top-module $(RTL_TOP) $(RTL)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_ula.sv ====
`timescale 1ns/1ps
`include "ula_consts.svh"

module tb_ula import ula_pkg::*; ();

	localparam int LINE_CYCLES = 2 * `ULA_H_TOTAL;
	localparam int FRAME_CYCLES = LINE_CYCLES * `ULA_V_TOTAL;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 40000;
	localparam byte_t BITMAP_BYTE = 8'hF0;
	localparam byte_t ATTR_BYTE = 8'h0A;
	localparam int SEL_HSYNC = 0;
	localparam int SEL_VSYNC = 1;
	localparam int SEL_INT = 2;
	localparam int SEL_READ = 3;

	logic clk14, rst_n, n_iorq, n_rd, n_wr, tape_in, cpu_drive;
	logic [15:0] addr;
	logic [4:0] kd;
	byte_t vd_in, vd_out, cpu_data;
	logic vd_oe, tape_out, beeper, rom_bank, screen_read, screen_bank;
	logic bright, hsync, vsync, csync, n_int;
	logic [2:0] ram_bank;
	scr_addr_t screen_addr;
	rgb_t rgb;
	int cycle = 0;
	int errors = 0;
	int checks = 0;

	// combinational screen memory with an address pattern outside the screen
	function automatic byte_t mem_byte(input scr_addr_t a);
		if (a[14:13] == 2'b10 && a < 15'h5800)
			return BITMAP_BYTE;
		if (a >= 15'h5800 && a < 15'h5B00)
			return ATTR_BYTE;
		return a[7:0] ^ {1'b0, a[14:8]};
	endfunction

	assign vd_in = cpu_drive ? cpu_data : mem_byte(screen_addr);

	ula_top i_dut (.*);

	initial begin
		clk14 = 1'b0;
		forever #20 clk14 = ~clk14;
	end

	always @(posedge clk14) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	task automatic compare(input string name, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	function automatic logic probe(input int sel);
		case (sel)
			SEL_HSYNC: return hsync;
			SEL_VSYNC: return vsync;
			SEL_INT: return n_int;
			default: return screen_read;
		endcase
	endfunction

	task automatic wait_level(input int sel, input logic level);
		@(negedge clk14);
		while (probe(sel) != level)
			@(negedge clk14);
	endtask

	task automatic wait_edge(input int sel, input logic level);
		wait_level(sel, !level);
		wait_level(sel, level);
	endtask

	task automatic tick();
		@(posedge clk14);
		#2;
	endtask

	task automatic io_write(input logic [15:0] a, input byte_t d);
		tick();
		addr = a;
		cpu_data = d;
		cpu_drive = 1'b1;
		n_iorq = 1'b0;
		n_wr = 1'b0;
		tick();
		n_iorq = 1'b1;
		n_wr = 1'b1;
		cpu_drive = 1'b0;
		@(negedge clk14);
	endtask

	task automatic measure_sync_timing();
		int t0, t1;
		wait_edge(SEL_HSYNC, 1'b1);
		t0 = cycle;
		wait_edge(SEL_HSYNC, 1'b0);
		compare("hsync width", cycle - t0, 2 * (`ULA_HSYNC_TO - `ULA_HSYNC_FROM));
		wait_edge(SEL_HSYNC, 1'b1);
		compare("hsync period", cycle - t0, LINE_CYCLES);
		wait_edge(SEL_INT, 1'b0);
		t0 = cycle;
		wait_edge(SEL_INT, 1'b1);
		compare("n_int width", cycle - t0, 2 * (`ULA_INT_TO - `ULA_INT_FROM));
		wait_edge(SEL_VSYNC, 1'b1);
		t1 = cycle;
		wait_edge(SEL_VSYNC, 1'b0);
		compare("vsync width", cycle - t1, (`ULA_VSYNC_TO - `ULA_VSYNC_FROM) * LINE_CYCLES);
		wait_edge(SEL_INT, 1'b0);
		compare("n_int period", cycle - t0, FRAME_CYCLES);
	endtask

	task automatic show_border();
		int border_cnt, black_cnt;
		border_cnt = 0;
		black_cnt = 0;
		io_write(16'h00FE, 8'h1D);
		compare("beeper", int'(beeper), 1);
		compare("tape_out", int'(tape_out), 1);
		tick();
		tape_in = 1'b1;
		@(negedge clk14);
		compare("tape_out", int'(tape_out), 0);
		// the line after the interrupt line is all border
		wait_edge(SEL_INT, 1'b1);
		wait_edge(SEL_HSYNC, 1'b0);
		repeat (LINE_CYCLES) begin
			@(negedge clk14);
			if (rgb == 3'b101)
				border_cnt++;
			if (rgb == 3'b000)
				black_cnt++;
		end
		compare("rgb border cycles", border_cnt,
			2 * (`ULA_H_TOTAL - (`ULA_HBLANK_TO - `ULA_HBLANK_FROM)));
		compare("rgb blank cycles", black_cnt, 2 * (`ULA_HBLANK_TO - `ULA_HBLANK_FROM));
	endtask

	task automatic read_keyboard();
		logic [4:0] kd_val;
		logic tape_val;
		kd_val = 5'($urandom);
		tape_val = 1'($urandom);
		tick();
		kd = kd_val;
		tape_in = tape_val;
		addr = 16'h00FE;
		n_iorq = 1'b0;
		n_rd = 1'b0;
		// output enable follows one cycle after the read strobe
		@(negedge clk14);
		compare("vd_oe", int'(vd_oe), 0);
		repeat (3) begin
			@(negedge clk14);
			compare("vd_oe", int'(vd_oe), 1);
			compare("vd_out", int'(vd_out), int'({1'b1, tape_val, 1'b1, kd_val}));
		end
		tick();
		n_iorq = 1'b1;
		n_rd = 1'b1;
		repeat (2) @(negedge clk14);
		compare("vd_oe", int'(vd_oe), 0);
	endtask

	task automatic count_screen_pixels();
		int ink_cnt, paper_cnt, read_cnt;
		ink_cnt = 0;
		paper_cnt = 0;
		read_cnt = 0;
		wait_edge(SEL_READ, 1'b1);
		repeat (LINE_CYCLES) begin
			@(negedge clk14);
			if (screen_read)
				read_cnt++;
			if (rgb == ATTR_BYTE[2:0])
				ink_cnt++;
			if (rgb == ATTR_BYTE[5:3])
				paper_cnt++;
		end
		// each set bitmap bit is one ink pixel of two cycles
		compare("rgb ink cycles", ink_cnt, `ULA_H_AREA / 8 * $countones(BITMAP_BYTE) * 2);
		compare("rgb paper cycles", paper_cnt,
			`ULA_H_AREA / 8 * (8 - $countones(BITMAP_BYTE)) * 2);
		checks++;
		if (read_cnt == 0) begin
			errors++;
			$display("no screen reads were seen during a screen line");
		end
	endtask

	task automatic lock_bank_port();
		io_write(16'h7FFD, 8'h1B);
		compare("ram_bank", int'(ram_bank), 3);
		compare("rom_bank", int'(rom_bank), 1);
		wait_level(SEL_READ, 1'b1);
		compare("screen_bank", int'(screen_bank), 1);
		io_write(16'h7FFD, 8'h20);
		io_write(16'h7FFD, 8'h1B);
		io_write(16'h7FFD, 8'h00);
		compare("ram_bank", int'(ram_bank), 0);
		compare("rom_bank", int'(rom_bank), 0);
		compare("screen_bank", int'(screen_bank), 0);
	endtask

	initial begin
		void'($urandom(32'h6b5eea15));
		rst_n = 1'b0;
		addr = '0;
		n_iorq = 1'b1;
		n_rd = 1'b1;
		n_wr = 1'b1;
		kd = '1;
		tape_in = 1'b0;
		cpu_drive = 1'b0;
		cpu_data = '0;
		repeat (7) @(posedge clk14);
		@(negedge clk14);
		compare("hsync", int'(hsync), 0);
		compare("vsync", int'(vsync), 0);
		compare("vd_oe", int'(vd_oe), 0);
		compare("beeper", int'(beeper), 0);
		compare("screen_read", int'(screen_read), 0);
		compare("rgb", int'({rgb, bright}), 0);
		compare("n_int", int'(n_int), 1);
		compare("csync", int'(csync), 1);
		compare("ram_bank", int'(ram_bank), 0);
		tick();
		rst_n = 1'b1;
		measure_sync_timing();
		show_border();
		read_keyboard();
		count_screen_pixels();
		lock_bank_port();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== source/ula_top.sv ====
`timescale 1ns/1ps

module ula_top import ula_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  logic [15:0] addr,
	input  logic        n_iorq,
	input  logic        n_rd,
	input  logic        n_wr,
	input  byte_t       vd_in,
	output byte_t       vd_out,
	output logic        vd_oe,
	input  logic [4:0]  kd,
	input  logic        tape_in,
	output logic        tape_out,
	output logic        beeper,
	output logic [2:0]  ram_bank,
	output logic        rom_bank,
	output logic        screen_read,
	output scr_addr_t   screen_addr,
	output logic        screen_bank,
	output rgb_t        rgb,
	output logic        bright,
	output logic        hsync,
	output logic        vsync,
	output logic        csync,
	output logic        n_int
);

	raster_t     raster;
	port_state_t ports;
	bus_t        bus;

	assign bus = '{addr: addr, n_iorq: n_iorq, n_rd: n_rd, n_wr: n_wr};

	assign tape_out = ports.tape_out;
	assign beeper = ports.beeper;
	assign ram_bank = ports.rambank;
	assign rom_bank = ports.rombank;

	raster_timing i_raster (
		.clk14  (clk14),
		.rst_n  (rst_n),
		.raster (raster),
		.n_int  (n_int)
	);

	port_regs i_ports (
		.clk14   (clk14),
		.rst_n   (rst_n),
		.bus     (bus),
		.vd_in   (vd_in),
		.kd      (kd),
		.tape_in (tape_in),
		.vd_out  (vd_out),
		.vd_oe   (vd_oe),
		.ports   (ports)
	);

	pixel_mixer i_mixer (
		.clk14       (clk14),
		.rst_n       (rst_n),
		.raster      (raster),
		.ports       (ports),
		.vd_in       (vd_in),
		.screen_read (screen_read),
		.screen_addr (screen_addr),
		.screen_bank (screen_bank),
		.rgb         (rgb),
		.bright      (bright),
		.hsync       (hsync),
		.vsync       (vsync),
		.csync       (csync)
	);

endmodule

// ==== source/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer import ula_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  raster_t     raster,
	input  port_state_t ports,
	input  byte_t       vd_in,
	output logic        screen_read,
	output scr_addr_t   screen_addr,
	output logic        screen_bank,
	output rgb_t        rgb,
	output logic        bright,
	output logic        hsync,
	output logic        vsync,
	output logic        csync
);

	byte_t     bitmap_next;
	byte_t     attr_next;
	byte_t     bitmap;
	byte_t     attr;
	scr_addr_t bitmap_addr;
	scr_addr_t attr_addr;
	logic      attr_read;
	logic      bitmap_read;
	logic      pixel;
	rgb_t      colour;

	// interleaved thirds: y7..6, y2..0, y5..3, then column
	assign bitmap_addr = {2'b10, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};
	assign attr_addr = {5'b10110, raster.vc[7:3], raster.hc[7:3]};

	// attribute on the even phase, bitmap on the odd one
	assign attr_read = screen_read && !raster.ck7;
	assign bitmap_read = screen_read && raster.ck7;
	assign screen_addr = raster.ck7 ? bitmap_addr : attr_addr;
	assign screen_bank = ports.vbank;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			screen_read <= 1'b0;
		else
			screen_read <= raster.screen_load;
	end

	always_ff @(posedge clk14) begin
		if (attr_read)
			attr_next <= vd_in;
		if (bitmap_read)
			bitmap_next <= vd_in;
	end

	// border shows as paper with black ink outside the screen
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			attr <= '0;
			bitmap <= '0;
		end else begin
			if (!raster.screen_show)
				attr <= {2'b00, ports.border, 3'b000};
			else if (raster.screen_update)
				attr <= attr_next;

			if (raster.screen_update)
				bitmap <= bitmap_next;
			else if (raster.ck7)
				bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	assign pixel = bitmap[7] ^ (attr[7] & raster.blink);
	assign colour = pixel ? attr[2:0] : attr[5:3];

	// outputs move once per pixel
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= '0;
			bright <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b1;
		end else if (raster.ck7) begin
			hsync <= raster.hsync;
			vsync <= raster.vsync;
			csync <= ~(raster.hsync ^ raster.vsync);
			if (raster.blank) begin
				rgb <= '0;
				bright <= 1'b0;
			end else begin
				rgb <= colour;
				// no bright on black
				bright <= attr[6] && (colour != 3'b000);
			end
		end
	end

endmodule

// ==== source/port_regs.sv ====
`timescale 1ns/1ps

module port_regs import ula_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  bus_t        bus,
	input  byte_t       vd_in,
	input  logic [4:0]  kd,
	input  logic        tape_in,
	output byte_t       vd_out,
	output logic        vd_oe,
	output port_state_t ports
);

	logic       fe_sel;
	logic       bank_sel;
	logic [4:0] port_fe;
	logic [5:0] port_7ffd;

	// #FE answers on any even address
	assign fe_sel = !bus.n_iorq && !bus.addr[0];

	// #7FFD partial decode needs A1 and A15 low and A14 or A13 high
	assign bank_sel = !bus.n_iorq && !bus.addr[1] && !bus.addr[15] &&
		(bus.addr[14] || bus.addr[13]);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			port_fe <= '0;
		else if (fe_sel && !bus.n_wr)
			port_fe <= vd_in[4:0];
	end

	// bit 5 locks the register until the next reset
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			port_7ffd <= '0;
		else if (bank_sel && !bus.n_wr && !ports.locked)
			port_7ffd <= vd_in[5:0];
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			vd_oe <= 1'b0;
		else
			vd_oe <= fe_sel && !bus.n_rd;
	end

	// keyboard half-row and tape level with the unused bits high
	assign vd_out = {1'b1, tape_in, 1'b1, kd};

	always_comb begin
		ports.border = port_fe[2:0];
		ports.tape_out = port_fe[3] ^ tape_in;
		ports.beeper = port_fe[4];
		ports.rambank = port_7ffd[2:0];
		ports.vbank = port_7ffd[3];
		ports.rombank = port_7ffd[4];
		ports.locked = port_7ffd[5];
	end

endmodule

// ==== source/raster_timing.sv ====
`timescale 1ns/1ps
`include "ula_consts.svh"

module raster_timing import ula_pkg::*; (
	input  logic    clk14,
	input  logic    rst_n,
	output raster_t raster,
	output logic    n_int
);

	// half-pixel counter, bit 0 is the ck7 phase
	logic [9:0] hc0;
	hcount_t    hc;
	vcount_t    vc;
	logic       line_end;
	logic       frame_end;
	logic       in_screen;
	logic       vsync0;
	logic       int_window;
	logic [4:0] frame_cnt;

	assign hc = hc0[9:1];
	assign line_end = (hc0 == 10'(2 * `ULA_H_TOTAL - 1));
	assign frame_end = (vc == vcount_t'(`ULA_V_TOTAL - 1));
	assign in_screen = (vc < vcount_t'(`ULA_V_AREA));
	assign vsync0 = (vc >= vcount_t'(`ULA_VSYNC_FROM)) && (vc < vcount_t'(`ULA_VSYNC_TO));

	assign int_window = (vc == vcount_t'(`ULA_INT_LINE)) &&
		(hc >= hcount_t'(`ULA_INT_FROM)) && (hc < hcount_t'(`ULA_INT_TO));

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc0 <= '0;
			if (frame_end)
				vc <= '0;
			else
				vc <= vc + 9'd1;
		end else begin
			hc0 <= hc0 + 10'd1;
		end
	end

	// interrupt strobe, frame counter steps as n_int falls
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_int <= 1'b1;
			frame_cnt <= '0;
		end else begin
			n_int <= ~int_window;
			if (int_window && n_int)
				frame_cnt <= frame_cnt + 5'd1;
		end
	end

	always_comb begin
		raster.hc = hc;
		raster.vc = vc;
		raster.ck7 = hc0[0];
		raster.hsync = (hc >= hcount_t'(`ULA_HSYNC_FROM)) && (hc < hcount_t'(`ULA_HSYNC_TO));
		raster.vsync = vsync0;
		raster.blank = vsync0 ||
			((hc >= hcount_t'(`ULA_HBLANK_FROM)) && (hc < hcount_t'(`ULA_HBLANK_TO)));
		// fetch starts on the last cycle of the previous line
		raster.screen_load = in_screen && ((hc < hcount_t'(`ULA_H_AREA)) || line_end);
		raster.screen_show = in_screen &&
			(hc >= hcount_t'(`ULA_SCREEN_DELAY - 1)) &&
			(hc < hcount_t'(`ULA_H_AREA + `ULA_SCREEN_DELAY - 1));
		// once per character, on the even half of its last pixel
		raster.screen_update = in_screen && (hc <= hcount_t'(`ULA_H_AREA)) &&
			(hc0[3:0] == 4'b1110);
		raster.blink = frame_cnt[4];
	end

endmodule

// ==== source/ula_pkg.sv ====
package ula_pkg;

	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;
	typedef logic [7:0] byte_t;
	// offset within a 16K screen bank
	typedef logic [14:0] scr_addr_t;
	// bit 2 green, bit 1 red, bit 0 blue
	typedef logic [2:0] rgb_t;

	typedef struct packed {
		hcount_t hc;
		vcount_t vc;
		logic    ck7;
		logic    hsync;
		logic    vsync;
		logic    blank;
		logic    screen_load;
		logic    screen_show;
		logic    screen_update;
		logic    blink;
	} raster_t;

	// CPU strobes, all active low
	typedef struct packed {
		logic [15:0] addr;
		logic        n_iorq;
		logic        n_rd;
		logic        n_wr;
	} bus_t;

	typedef struct packed {
		rgb_t       border;
		logic       beeper;
		logic       tape_out;
		logic [2:0] rambank;
		logic       vbank;
		logic       rombank;
		logic       locked;
	} port_state_t;

endpackage

// ==== source/ula_consts.svh ====
`ifndef ULA_CONSTS_SVH
`define ULA_CONSTS_SVH

// visible screen area in pixels and lines
`define ULA_H_AREA 256
`define ULA_V_AREA 192

// pixel pipeline latency between fetch and output
`define ULA_SCREEN_DELAY 8

// Pentagon frame geometry
`define ULA_H_TOTAL 448
`define ULA_V_TOTAL 320

// horizontal sync, in pixel columns
`define ULA_HSYNC_FROM 328
`define ULA_HSYNC_TO 361

// horizontal blanking covers the sync and both porches
`define ULA_HBLANK_FROM 320
`define ULA_HBLANK_TO 384

// vertical sync lines, also blanked
`define ULA_VSYNC_FROM 248
`define ULA_VSYNC_TO 256

// frame interrupt, one window on a single line
`define ULA_INT_LINE 239
`define ULA_INT_FROM 318
`define ULA_INT_TO 384

`endif
